// ==== bench/exu_stimulus.txt ====
# hex: reg1 reg2 pc imm alu_op src1 src2 csr_op csr_rdata csr_addr wen wreg store load ebreak
# then expected: wdata csr_wdata csr_wen fwd_en
00001234 00000010 00000100 00000000 0 1 1 0 00000000 000 1 01 0 0 0 00001244 00000000 0 1
00000005 00000007 00000104 00000000 1 1 1 0 00000000 000 1 02 0 0 0 fffffffe 00000000 0 1
ff00ff00 00000000 00000108 0f0f0f0f 2 1 2 0 00000000 000 1 03 0 0 0 f00ff00f 00000000 0 1
12340000 00005678 0000010c 00000000 3 1 1 0 00000000 000 1 04 0 0 0 12345678 00000000 0 1
f0f0f0f0 00000000 00000110 ff00ff00 4 1 2 0 00000000 000 1 05 0 0 0 f000f000 00000000 0 1
80000000 00000024 00000114 00000000 5 1 1 0 00000000 000 1 06 0 0 0 08000000 00000000 0 1
80000000 00000000 00000118 00000004 6 1 2 0 00000000 000 1 07 0 0 0 f8000000 00000000 0 1
00000001 0000003f 0000011c 00000000 7 1 1 0 00000000 000 1 08 0 0 0 80000000 00000000 0 1
00000001 ffffffff 00000120 00000000 8 1 1 0 00000000 000 1 09 0 0 0 00000001 00000000 0 1
00000001 ffffffff 00000124 00000000 9 1 1 0 00000000 000 1 0a 0 0 0 00000000 00000000 0 1
ffffffff 00000001 00000128 00000000 9 1 1 0 00000000 000 1 0b 0 0 0 00000001 00000000 0 1
00000000 00000000 00000200 00001000 0 2 2 0 00000000 000 1 0c 0 0 0 00001200 00000000 0 1
00000000 00000000 00000300 00000000 0 2 3 0 00000000 000 1 01 0 0 0 00000304 00000000 0 1
00000003 00000004 00000304 00000000 0 1 1 0 00000000 000 0 0c 0 0 0 00000007 00000000 0 0
00000009 00000000 00000308 00000001 0 1 2 0 00000000 000 1 00 0 0 0 0000000a 00000000 0 0
deadbeef 00000000 0000030c 00000000 0 3 0 1 00000055 300 1 0d 0 0 0 00000055 deadbeef 1 1
000000f0 00000000 00000310 00000000 0 3 0 2 0000000f 341 1 0e 0 0 0 0000000f 000000ff 1 1
00000000 00000000 00000400 00000000 0 0 0 3 00000000 341 0 00 0 0 0 00000000 00000400 1 0
00000040 11223344 00000404 00000000 0 1 2 0 00000000 000 0 00 3 0 0 00000040 00000000 0 0
00000040 000000a5 00000408 00000001 0 1 2 0 00000000 000 0 00 1 0 0 00000041 00000000 0 0
00000040 0000beef 0000040c 00000002 0 1 2 0 00000000 000 0 00 2 0 0 00000042 00000000 0 0
00000040 00000000 00000410 00000000 0 1 2 0 00000000 000 1 10 0 3 0 beefa544 00000000 0 1
00000040 00000000 00000414 00000001 0 1 2 0 00000000 000 1 11 0 1 0 ffffffa5 00000000 0 1
00000040 00000000 00000418 00000001 0 1 2 0 00000000 000 1 12 0 4 0 000000a5 00000000 0 1
00000040 00000000 0000041c 00000002 0 1 2 0 00000000 000 1 13 0 2 0 ffffbeef 00000000 0 1
00000040 00000000 00000420 00000002 0 1 2 0 00000000 000 1 14 0 5 0 0000beef 00000000 0 1
00000040 00000000 00000424 00000000 0 1 2 0 00000000 000 1 15 0 1 0 00000044 00000000 0 1
00000080 00000000 00000428 00000000 0 1 2 0 00000000 000 1 16 0 3 0 00000000 00000000 0 1
00000000 00000000 0000042c 00000000 0 0 0 0 00000000 000 0 00 0 0 1 00000000 00000000 0 0

// ==== bench/exu_tb.sv ====
`timescale 1ns/10ps
`default_nettype none

module exu_tb;

	import exu_pkg::*;

	localparam int clk_period = 40;
	localparam int cycles_per_line = 60;

	// expected results for one stimulus line
	typedef struct packed {
		logic [xlen-1:0] wdata;
		logic [xlen-1:0] csr_wdata;
		logic            csr_wen;
		logic            fwd_en;
	} expect_t;

	logic        clock;
	logic        reset;
	logic        in_valid;
	ds_to_es_t   in_bus;
	logic        in_allowin;
	es_forward_t forward;
	logic        wb_allowin;
	logic        wb_valid;
	ms_to_ws_t   wb_bus;

	ds_to_es_t   stim_q[$];
	expect_t     exp_q[$];
	int          pending[$];
	int          line_errs[];
	int          n_lines;
	int          next_idx;
	int          last_in;
	int          errors;
	int          reset_errs;
	int          tests_done;
	int          tests_bad;
	logic        loaded;
	logic [31:0] lfsr;

	exu_top dut (
		.clock        (clock),
		.reset        (reset),
		.in_valid_i   (in_valid),
		.in_bus_i     (in_bus),
		.in_allowin_o (in_allowin),
		.forward_o    (forward),
		.wb_allowin_i (wb_allowin),
		.wb_valid_o   (wb_valid),
		.wb_bus_o     (wb_bus)
	);

	initial begin
		clock = 1'b0;
		forever #(clk_period / 2) clock = ~clock;
	end

	// fibonacci lfsr with taps 32 22 2 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	function automatic logic random_bit();
		lfsr = lfsr_next(lfsr);
		return lfsr[0];
	endfunction

	task automatic load_stimulus();
		int          fd;
		int          cnt;
		string       line;
		logic [31:0] f [19];
		ds_to_es_t   d;
		expect_t     e;
		fd = $fopen("bench/exu_stimulus.txt", "r");
		if (fd == 0) begin
			$display("could not open bench/exu_stimulus.txt");
			errors++;
			return;
		end
		while (!$feof(fd)) begin
			line = "";
			cnt = $fgets(line, fd);
			if (cnt == 0 || line.getc(0) == "#") begin
				continue;
			end
			cnt = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
				f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7], f[8], f[9],
				f[10], f[11], f[12], f[13], f[14], f[15], f[16], f[17], f[18]);
			if (cnt != 19) begin
				continue;
			end
			d.reg1      = f[0];
			d.reg2      = f[1];
			d.pc        = f[2];
			d.imm       = f[3];
			d.alu_op    = alu_op_t'(f[4][3:0]);
			d.src1_sel  = src1_sel_t'(f[5][1:0]);
			d.src2_sel  = src2_sel_t'(f[6][1:0]);
			d.csr_op    = csr_op_t'(f[7][2:0]);
			d.csr_rdata = f[8];
			d.csr_addr  = f[9][11:0];
			d.wen       = f[10][0];
			d.wreg      = f[11][4:0];
			d.store     = store_t'(f[12][1:0]);
			d.load      = load_t'(f[13][2:0]);
			d.ebreak    = f[14][0];
			e.wdata     = f[15];
			e.csr_wdata = f[16];
			e.csr_wen   = f[17][0];
			e.fwd_en    = f[18][0];
			stim_q.push_back(d);
			exp_q.push_back(e);
		end
		$fclose(fd);
	endtask

	task automatic report_mismatch(input int idx, input string what,
			input logic [31:0] got, input logic [31:0] want);
		$display("FAIL %0t: test %0d %s got %h expected %h", $time, idx, what, got, want);
		errors++;
		line_errs[idx]++;
	endtask

	task automatic verify_reset_state();
		if (wb_valid !== 1'b0 || forward.fwd_en !== 1'b0 || forward.csr_fwd_en !== 1'b0
				|| in_allowin !== 1'b1) begin
			$display("FAIL %0t: reset state wb_valid %b fwd_en %b csr_fwd_en %b allowin %b",
				$time, wb_valid, forward.fwd_en, forward.csr_fwd_en, in_allowin);
			errors++;
			reset_errs++;
		end
	endtask

	// instruction sits in execute one cycle after acceptance
	task automatic compare_forward(input int idx);
		ds_to_es_t d;
		expect_t   e;
		d = stim_q[idx];
		e = exp_q[idx];
		if (forward.need_stall !== 1'b1) begin
			report_mismatch(idx, "need_stall", forward.need_stall, 32'd1);
		end
		if (forward.fwd_en !== e.fwd_en) begin
			report_mismatch(idx, "fwd_en", forward.fwd_en, e.fwd_en);
		end
		if (forward.wreg !== d.wreg) begin
			report_mismatch(idx, "fwd wreg", forward.wreg, d.wreg);
		end
		// a load's alu result is its address, not its writeback data
		if (d.load == load_none && forward.alu_result !== e.wdata) begin
			report_mismatch(idx, "fwd alu_result", forward.alu_result, e.wdata);
		end
		if (forward.csr_fwd_en !== e.csr_wen) begin
			report_mismatch(idx, "csr_fwd_en", forward.csr_fwd_en, e.csr_wen);
		end
		if (e.csr_wen && forward.csr_wdata !== e.csr_wdata) begin
			report_mismatch(idx, "fwd csr_wdata", forward.csr_wdata, e.csr_wdata);
		end
		if (e.csr_wen && forward.csr_addr !== d.csr_addr) begin
			report_mismatch(idx, "fwd csr_addr", forward.csr_addr, d.csr_addr);
		end
		if (forward.csr_op !== d.csr_op) begin
			report_mismatch(idx, "fwd csr_op", forward.csr_op, d.csr_op);
		end
	endtask

	task automatic check_writeback(input int idx);
		ds_to_es_t d;
		expect_t   e;
		d = stim_q[idx];
		e = exp_q[idx];
		if (wb_bus.wen !== d.wen) begin
			report_mismatch(idx, "wen", wb_bus.wen, d.wen);
		end
		if (wb_bus.wreg !== d.wreg) begin
			report_mismatch(idx, "wreg", wb_bus.wreg, d.wreg);
		end
		if (wb_bus.wdata !== e.wdata) begin
			report_mismatch(idx, "wdata", wb_bus.wdata, e.wdata);
		end
		if (wb_bus.csr_wen !== e.csr_wen) begin
			report_mismatch(idx, "csr_wen", wb_bus.csr_wen, e.csr_wen);
		end
		if (e.csr_wen && wb_bus.csr_wdata !== e.csr_wdata) begin
			report_mismatch(idx, "csr_wdata", wb_bus.csr_wdata, e.csr_wdata);
		end
		if (e.csr_wen && wb_bus.csr_addr !== d.csr_addr) begin
			report_mismatch(idx, "csr_addr", wb_bus.csr_addr, d.csr_addr);
		end
		if (wb_bus.ebreak !== d.ebreak) begin
			report_mismatch(idx, "ebreak", wb_bus.ebreak, d.ebreak);
		end
		tests_done++;
		if (line_errs[idx] == 0) begin
			$display("test %0d: pass", idx);
		end else begin
			tests_bad++;
			$display("test %0d: fail", idx);
		end
	endtask

	initial begin
		reset = 1'b1;
		in_valid = 1'b0;
		in_bus = '0;
		wb_allowin = 1'b0;
		lfsr = 32'd78952;
		loaded = 1'b0;
		errors = 0;
		reset_errs = 0;
		tests_done = 0;
		tests_bad = 0;
		next_idx = 0;
		last_in = -1;
		load_stimulus();
		n_lines = stim_q.size();
		line_errs = new[n_lines];
		loaded = 1'b1;
		repeat (4) begin
			@(negedge clock);
			verify_reset_state();
		end
		reset = 1'b0;
		@(negedge clock);
		verify_reset_state();
		$display("test reset: %s", (reset_errs == 0) ? "pass" : "fail");
		while (tests_done < n_lines) begin
			@(negedge clock);
			if (last_in >= 0) begin
				compare_forward(last_in);
			end
			last_in = -1;
			in_valid = 1'b0;
			if (next_idx < n_lines && random_bit()) begin
				in_valid = 1'b1;
				in_bus = stim_q[next_idx];
			end
			wb_allowin = random_bit();
			#1;
			// refusal only when both stages are full and writeback stalls
			if (in_allowin !== !(pending.size() == 2 && !wb_allowin)) begin
				$display("FAIL %0t: in_allowin %b with %0d in flight, wb_allowin %b",
					$time, in_allowin, pending.size(), wb_allowin);
				errors++;
			end
			if (wb_valid && wb_allowin) begin
				if (pending.size() == 0) begin
					$display("writeback at %0t with no instruction outstanding", $time);
					errors++;
				end else begin
					check_writeback(pending.pop_front());
				end
			end
			if (in_valid && in_allowin) begin
				pending.push_back(next_idx);
				last_in = next_idx;
				next_idx++;
			end
		end
		$display("summary: %0d tests, %0d passed, %0d failed, %0d errors",
			n_lines, tests_done - tests_bad, tests_bad, errors);
		if (errors == 0 && n_lines > 0) begin
			$display("TESTS PASSED");
		end else begin
			$display("TESTS FAILED");
		end
		$finish;
	end

	initial begin
		wait (loaded);
		#((n_lines + 1) * cycles_per_line * clk_period);
		$display("timeout: only %0d of %0d instructions reached writeback",
			tests_done, n_lines);
		$display("TESTS FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// ==== list.f ====
rtl/exu_pkg.sv
rtl/exu_alu.sv
rtl/exu_ex_stage.sv
rtl/exu_mem_stage.sv
rtl/exu_top.sv
bench/exu_tb.sv

// ==== rtl/exu_alu.sv ====
`timescale 1ns/10ps
`default_nettype none

module exu_alu (
	input  wire logic [31:0]     src1_i,
	input  wire logic [31:0]     src2_i,
	input  wire exu_pkg::alu_op_t op_i,
	output logic [31:0]          result_o
);

	import exu_pkg::*;

	logic [4:0]  shamt;
	logic        lt_signed;
	logic        lt_unsigned;

	// only the low five bits count for rv32 shifts
	assign shamt = src2_i[4:0];

	assign lt_signed   = $signed(src1_i) < $signed(src2_i);
	assign lt_unsigned = src1_i < src2_i;

	always_comb begin
		case (op_i)
			alu_add: begin
				result_o = src1_i + src2_i;
			end
			alu_sub: begin
				result_o = src1_i - src2_i;
			end
			alu_xor: begin
				result_o = src1_i ^ src2_i;
			end
			alu_or: begin
				result_o = src1_i | src2_i;
			end
			alu_and: begin
				result_o = src1_i & src2_i;
			end
			alu_srl: begin
				result_o = src1_i >> shamt;
			end
			alu_sra: begin
				result_o = $unsigned($signed(src1_i) >>> shamt);
			end
			alu_sll: begin
				result_o = src1_i << shamt;
			end
			alu_sltu: begin
				result_o = {31'd0, lt_unsigned};
			end
			alu_slt: begin
				result_o = {31'd0, lt_signed};
			end
			default: begin
				result_o = '0;
			end
		endcase
	end

endmodule

`default_nettype wire

// ==== rtl/exu_ex_stage.sv ====
`timescale 1ns/10ps
`default_nettype none

module exu_ex_stage (
	input  wire logic                 clock,
	input  wire logic                 reset,
	input  wire logic                 in_valid_i,
	input  wire exu_pkg::ds_to_es_t   in_bus_i,
	output logic                      es_allowin_o,
	input  wire logic                 ms_allowin_i,
	output logic                      es_to_ms_valid_o,
	output exu_pkg::es_to_ms_t        es_to_ms_bus_o,
	output exu_pkg::es_forward_t      forward_o
);

	import exu_pkg::*;

	ds_to_es_t       ds_r;
	logic            es_valid;
	logic [xlen-1:0] src1;
	logic [xlen-1:0] src2;
	logic [xlen-1:0] alu_result;
	logic [xlen-1:0] csr_wdata;
	logic            csr_wen;

	// always ready, so only the downstream stage can hold us
	assign es_allowin_o     = !es_valid || ms_allowin_i;
	assign es_to_ms_valid_o = es_valid;

	always_ff @(posedge clock) begin
		if (reset) begin
			es_valid <= 1'b0;
		end else if (es_allowin_o) begin
			es_valid <= in_valid_i;
		end
	end

	always_ff @(posedge clock) begin
		if (in_valid_i && es_allowin_o) begin
			ds_r <= in_bus_i;
		end
	end

	// operand muxes
	always_comb begin
		case (ds_r.src1_sel)
			src1_reg1: begin
				src1 = ds_r.reg1;
			end
			src1_pc: begin
				src1 = ds_r.pc;
			end
			src1_csr: begin
				src1 = ds_r.csr_rdata;
			end
			default: begin
				src1 = '0;
			end
		endcase
	end

	always_comb begin
		case (ds_r.src2_sel)
			src2_reg2: begin
				src2 = ds_r.reg2;
			end
			src2_imm: begin
				src2 = ds_r.imm;
			end
			src2_four: begin
				src2 = 32'd4;
			end
			default: begin
				src2 = '0;
			end
		endcase
	end

	exu_alu u_alu (
		.src1_i   (src1),
		.src2_i   (src2),
		.op_i     (ds_r.alu_op),
		.result_o (alu_result)
	);

	// csr write value; ecall saves the pc for mepc
	always_comb begin
		case (ds_r.csr_op)
			csr_csrrw: begin
				csr_wdata = ds_r.reg1;
			end
			csr_csrrs: begin
				csr_wdata = ds_r.reg1 | ds_r.csr_rdata;
			end
			csr_ecall: begin
				csr_wdata = ds_r.pc;
			end
			default: begin
				csr_wdata = '0;
			end
		endcase
	end

	assign csr_wen = ds_r.csr_op inside {csr_csrrw, csr_csrrs, csr_ecall};

	always_comb begin
		es_to_ms_bus_o.wen        = ds_r.wen;
		es_to_ms_bus_o.wreg       = ds_r.wreg;
		es_to_ms_bus_o.alu_result = alu_result;
		es_to_ms_bus_o.store_data = ds_r.reg2;
		es_to_ms_bus_o.store      = ds_r.store;
		es_to_ms_bus_o.load       = ds_r.load;
		es_to_ms_bus_o.csr_wen    = csr_wen;
		es_to_ms_bus_o.csr_addr   = ds_r.csr_addr;
		es_to_ms_bus_o.csr_wdata  = csr_wdata;
		es_to_ms_bus_o.ebreak     = ds_r.ebreak;
	end

	// x0 writes never forward
	always_comb begin
		forward_o.need_stall = 1'b1;
		forward_o.fwd_en     = ds_r.wen && (ds_r.wreg != 5'd0) && es_valid;
		forward_o.wreg       = ds_r.wreg;
		forward_o.alu_result = alu_result;
		forward_o.csr_fwd_en = csr_wen && es_valid;
		forward_o.csr_addr   = ds_r.csr_addr;
		forward_o.csr_wdata  = csr_wdata;
		forward_o.csr_op     = ds_r.csr_op;
	end

endmodule

`default_nettype wire

// ==== rtl/exu_mem_stage.sv ====
`timescale 1ns/10ps
`default_nettype none

module exu_mem_stage (
	input  wire logic               clock,
	input  wire logic               reset,
	input  wire logic               es_valid_i,
	input  wire exu_pkg::es_to_ms_t es_bus_i,
	output logic                    ms_allowin_o,
	input  wire logic               wb_allowin_i,
	output logic                    wb_valid_o,
	output exu_pkg::ms_to_ws_t      wb_bus_o
);

	import exu_pkg::*;

	logic [xlen-1:0]       mem [mem_words];
	logic                  ms_valid;
	ms_to_ws_t             ms_r;
	logic                  accept;
	logic [mem_addr_w-1:0] word_idx;
	logic [1:0]            lane;
	logic [xlen-1:0]       rd_word;
	logic [xlen-1:0]       st_word;
	logic [7:0]            ld_byte;
	logic [15:0]           ld_half;
	logic [xlen-1:0]       wdata;

	assign ms_allowin_o = !ms_valid || wb_allowin_i;
	assign accept       = es_valid_i && ms_allowin_o;
	assign wb_valid_o   = ms_valid;
	assign wb_bus_o     = ms_r;

	assign word_idx = es_bus_i.alu_result[mem_addr_w+1:2];
	assign lane     = es_bus_i.alu_result[1:0];
	assign rd_word  = mem[word_idx];

	// merge narrow store data into the old word
	always_comb begin
		st_word = rd_word;
		case (es_bus_i.store)
			store_byte: begin
				st_word[{lane, 3'b000} +: 8] = es_bus_i.store_data[7:0];
			end
			store_half: begin
				st_word[{lane[1], 4'b0000} +: 16] = es_bus_i.store_data[15:0];
			end
			store_word: begin
				st_word = es_bus_i.store_data;
			end
			default: begin
			end
		endcase
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			for (int i = 0; i < mem_words; i++) begin
				mem[i] <= '0;
			end
		end else if (accept && (es_bus_i.store != store_none)) begin
			mem[word_idx] <= st_word;
		end
	end

	// load lane pick and extension
	assign ld_byte = rd_word[{lane, 3'b000} +: 8];
	assign ld_half = rd_word[{lane[1], 4'b0000} +: 16];

	always_comb begin
		case (es_bus_i.load)
			load_lb:  wdata = {{24{ld_byte[7]}}, ld_byte};
			load_lbu: wdata = {24'd0, ld_byte};
			load_lh:  wdata = {{16{ld_half[15]}}, ld_half};
			load_lhu: wdata = {16'd0, ld_half};
			load_lw:  wdata = rd_word;
			default:  wdata = es_bus_i.alu_result;
		endcase
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			ms_valid <= 1'b0;
		end else if (ms_allowin_o) begin
			ms_valid <= es_valid_i;
		end
	end

	always_ff @(posedge clock) begin
		if (accept) begin
			ms_r.wen       <= es_bus_i.wen;
			ms_r.wreg      <= es_bus_i.wreg;
			ms_r.wdata     <= wdata;
			ms_r.csr_wen   <= es_bus_i.csr_wen;
			ms_r.csr_addr  <= es_bus_i.csr_addr;
			ms_r.csr_wdata <= es_bus_i.csr_wdata;
			ms_r.ebreak    <= es_bus_i.ebreak;
		end
	end

endmodule

`default_nettype wire

// ==== rtl/exu_pkg.sv ====
`default_nettype none

package exu_pkg;

	localparam int xlen = 32;

	// data memory depth in words, indexed by address bits 7:2
	localparam int mem_words = 64;
	localparam int mem_addr_w = $clog2(mem_words);

	typedef enum logic [3:0] {
		alu_add  = 4'd0,
		alu_sub  = 4'd1,
		alu_xor  = 4'd2,
		alu_or   = 4'd3,
		alu_and  = 4'd4,
		alu_srl  = 4'd5,
		alu_sra  = 4'd6,
		alu_sll  = 4'd7,
		alu_sltu = 4'd8,
		alu_slt  = 4'd9
	} alu_op_t;

	// first alu source
	typedef enum logic [1:0] {
		src1_zero = 2'd0,
		src1_reg1 = 2'd1,
		src1_pc   = 2'd2,
		src1_csr  = 2'd3
	} src1_sel_t;

	// second alu source
	typedef enum logic [1:0] {
		src2_zero = 2'd0,
		src2_reg2 = 2'd1,
		src2_imm  = 2'd2,
		src2_four = 2'd3
	} src2_sel_t;

	typedef enum logic [2:0] {
		csr_none  = 3'd0,
		csr_csrrw = 3'd1,
		csr_csrrs = 3'd2,
		csr_ecall = 3'd3
	} csr_op_t;

	typedef enum logic [1:0] {
		store_none = 2'd0,
		store_byte = 2'd1,
		store_half = 2'd2,
		store_word = 2'd3
	} store_t;

	typedef enum logic [2:0] {
		load_none = 3'd0,
		load_lb   = 3'd1,
		load_lh   = 3'd2,
		load_lw   = 3'd3,
		load_lbu  = 3'd4,
		load_lhu  = 3'd5
	} load_t;

	// decoded instruction entering execute
	typedef struct packed {
		logic [xlen-1:0] reg1;
		logic [xlen-1:0] reg2;
		logic [xlen-1:0] pc;
		logic [xlen-1:0] imm;
		alu_op_t         alu_op;
		src1_sel_t       src1_sel;
		src2_sel_t       src2_sel;
		csr_op_t         csr_op;
		logic [xlen-1:0] csr_rdata;
		logic [11:0]     csr_addr;
		logic            wen;
		logic [4:0]      wreg;
		store_t          store;
		load_t           load;
		logic            ebreak;
	} ds_to_es_t;

	typedef struct packed {
		logic            wen;
		logic [4:0]      wreg;
		logic [xlen-1:0] alu_result;
		logic [xlen-1:0] store_data;
		store_t          store;
		load_t           load;
		logic            csr_wen;
		logic [11:0]     csr_addr;
		logic [xlen-1:0] csr_wdata;
		logic            ebreak;
	} es_to_ms_t;

	// bypass info back toward decode
	typedef struct packed {
		logic            need_stall;
		logic            fwd_en;
		logic [4:0]      wreg;
		logic [xlen-1:0] alu_result;
		logic            csr_fwd_en;
		logic [11:0]     csr_addr;
		logic [xlen-1:0] csr_wdata;
		csr_op_t         csr_op;
	} es_forward_t;

	typedef struct packed {
		logic            wen;
		logic [4:0]      wreg;
		logic [xlen-1:0] wdata;
		logic            csr_wen;
		logic [11:0]     csr_addr;
		logic [xlen-1:0] csr_wdata;
		logic            ebreak;
	} ms_to_ws_t;

endpackage

`default_nettype wire

// ==== rtl/exu_top.sv ====
`timescale 1ns/10ps
`default_nettype none

module exu_top (
	input  wire logic                 clock,
	input  wire logic                 reset,
	input  wire logic                 in_valid_i,
	input  wire exu_pkg::ds_to_es_t   in_bus_i,
	output logic                      in_allowin_o,
	output exu_pkg::es_forward_t      forward_o,
	input  wire logic                 wb_allowin_i,
	output logic                      wb_valid_o,
	output exu_pkg::ms_to_ws_t        wb_bus_o
);

	import exu_pkg::*;

	// execute to memory link
	logic      es_to_ms_valid;
	es_to_ms_t es_to_ms_bus;
	logic      ms_allowin;

	exu_ex_stage u_ex_stage (
		.clock            (clock),
		.reset            (reset),
		.in_valid_i       (in_valid_i),
		.in_bus_i         (in_bus_i),
		.es_allowin_o     (in_allowin_o),
		.ms_allowin_i     (ms_allowin),
		.es_to_ms_valid_o (es_to_ms_valid),
		.es_to_ms_bus_o   (es_to_ms_bus),
		.forward_o        (forward_o)
	);

	exu_mem_stage u_mem_stage (
		.clock        (clock),
		.reset        (reset),
		.es_valid_i   (es_to_ms_valid),
		.es_bus_i     (es_to_ms_bus),
		.ms_allowin_o (ms_allowin),
		.wb_allowin_i (wb_allowin_i),
		.wb_valid_o   (wb_valid_o),
		.wb_bus_o     (wb_bus_o)
	);

endmodule

`default_nettype wire

// ==== run.sh ====
#!/bin/sh
# build and run the exu testbench with verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module exu_tb -f list.f -o exu_sim
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

out=$(./obj_dir/exu_sim)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if echo "$out" | grep -q "^TESTS PASSED$"; then
	exit 0
fi
exit 1
